// File: logic/tinker_pkg.sv
// Tinker core package with widths, opcode encodings, FSM states and opcode classes
package tinker_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int XLEN     = 64;  // Data and address word
    localparam int INSTR_W  = 32;  // Instruction word
    localparam int REG_AW   = 5;   // Register index
    localparam int OPCODE_W = 5;   // Opcode field
    localparam int LIT_W    = 12;  // Signed literal field
    localparam int NUM_REGS = 32;  // r0 reads as zero

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;

    // ----------------------------------------------------------------------
    // Opcodes and FSM states
    // ----------------------------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OP_AND   = 5'b00000,
        OP_OR    = 5'b00001,
        OP_XOR   = 5'b00010,
        OP_NOT   = 5'b00011,  // Unary, rs only
        OP_SHR   = 5'b00100,
        OP_SHRI  = 5'b00101,  // Arithmetic shift by literal
        OP_SHL   = 5'b00110,
        OP_SHLI  = 5'b00111,
        OP_BR    = 5'b01000,  // Absolute, target in rd
        OP_BRR   = 5'b01001,  // PC relative by rd
        OP_BRGT  = 5'b01110,  // Signed rs > rt
        OP_LOAD  = 5'b10000,
        OP_MOV   = 5'b10001,
        OP_MOVI  = 5'b10010,
        OP_STORE = 5'b10011,
        OP_ADD   = 5'b11000,
        OP_ADDI  = 5'b11001,
        OP_SUB   = 5'b11010,
        OP_SUBI  = 5'b11011,
        OP_HALT  = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALTED
    } state_t;

    // ----------------------------------------------------------------------
    // Opcode classes
    // ----------------------------------------------------------------------
    function automatic logic is_load(opcode_t op);
        return op == OP_LOAD;
    endfunction

    function automatic logic is_store(opcode_t op);
        return op == OP_STORE;
    endfunction

    function automatic logic is_branch(opcode_t op);
        return op == OP_BR || op == OP_BRR || op == OP_BRGT;
    endfunction

    // Second ALU operand comes from the literal
    function automatic logic uses_literal(opcode_t op);
        return op == OP_ADDI || op == OP_SUBI || op == OP_SHRI || op == OP_SHLI ||
               op == OP_MOVI || op == OP_LOAD || op == OP_STORE;
    endfunction

    function automatic logic writes_reg(opcode_t op);
        return !(is_store(op) || is_branch(op) || op == OP_HALT);
    endfunction

endpackage

// File: logic/inst_fields_if.sv
// Decoded instruction fields passed from the decoder to the datapath units
interface inst_fields_if
    import tinker_pkg::*;
();

    opcode_t   opcode;  // Current operation
    reg_addr_t rd;      // Destination, also branch target and store base
    reg_addr_t rs;      // First source, remapped to rd for addi/subi
    reg_addr_t rt;      // Second source
    word_t     imm;     // Sign-extended literal

    // Decoder owns every field
    modport decoder (
        output opcode, rd, rs, rt, imm
    );

    // Control, register file, ALU and PC logic only read
    modport user (
        input opcode, rd, rs, rt, imm
    );

endinterface

// File: logic/inst_decoder.sv
// Instruction register and field decoder with the addi/subi source remap
module inst_decoder
    import tinker_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           ir_write,  // High during FETCH
    input  instr_t         instr_in,  // Low word of memory read data
    inst_fields_if.decoder fields
);

    instr_t  ir;  // Instruction register
    opcode_t op;  // Opcode of held instruction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (ir_write) begin
            ir <= instr_in;  // Captured at end of FETCH
        end
    end

    // ----------------------------------------------------------------------
    // Field split
    // ----------------------------------------------------------------------
    assign op            = opcode_t'(ir[INSTR_W-1 -: OPCODE_W]);  // Bits 31..27
    assign fields.opcode = op;
    assign fields.rd     = ir[26:22];
    assign fields.rt     = ir[16:12];

    // Literal is two's complement, widen to a full word
    assign fields.imm = {{(XLEN-LIT_W){ir[LIT_W-1]}}, ir[LIT_W-1:0]};

    // addi/subi accumulate into rd, so rd is also the first source
    assign fields.rs = (op == OP_ADDI || op == OP_SUBI) ? ir[26:22]
                                                        : ir[21:17];

endmodule

// File: logic/reg_file_bank.sv
// General register file, three combinational reads and one clocked write
module reg_file_bank
    import tinker_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        write_en,    // High in WRITEBACK for writing ops
    input  word_t       write_data,  // ALU or load result
    inst_fields_if.user fields,
    output word_t       rs_val,
    output word_t       rt_val,
    output word_t       rd_val
);

    word_t regs [NUM_REGS];  // r0 never written

    // ----------------------------------------------------------------------
    // Write port, addressed by rd
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && fields.rd != '0) begin
            regs[fields.rd] <= write_data;  // Drop writes to r0
        end
    end

    // ----------------------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------------------
    assign rs_val = regs[fields.rs];  // First ALU operand, store data
    assign rt_val = regs[fields.rt];  // Second ALU operand, brgt compare
    assign rd_val = regs[fields.rd];  // Branch target, store base

endmodule

// File: logic/alu_unit.sv
// Combinational ALU with register or literal second operand
module alu_unit
    import tinker_pkg::*;
(
    inst_fields_if.user fields,
    input  word_t       rs_val,  // First operand
    input  word_t       rt_val,
    output word_t       result
);

    word_t op_b;  // Second operand after select

    // Literal class replaces rt
    assign op_b = uses_literal(fields.opcode) ? fields.imm : rt_val;

    // ----------------------------------------------------------------------
    // Operations
    // ----------------------------------------------------------------------
    always_comb begin
        case (fields.opcode)
            OP_ADD, OP_ADDI: begin
                result = rs_val + op_b;
            end
            OP_SUB, OP_SUBI: begin
                result = rs_val - op_b;
            end
            OP_AND:  result = rs_val & op_b;
            OP_OR:   result = rs_val | op_b;
            OP_XOR:  result = rs_val ^ op_b;
            OP_NOT:  result = ~rs_val;               // rt ignored
            OP_SHR:  result = rs_val >> op_b;        // Zero fill
            OP_SHRI: result = $signed(rs_val) >>> op_b;  // Sign fill
            OP_SHL, OP_SHLI: begin
                result = rs_val << op_b;
            end
            OP_MOV:  result = rs_val;                // Register copy
            OP_MOVI: result = op_b;                  // Literal copy
            OP_LOAD, OP_STORE: begin
                result = rs_val + fields.imm;        // Load address
            end
            default: result = '0;                    // Branches, halt, unknown
        endcase
    end

endmodule

// File: logic/pc_unit.sv
// Program counter register with sequential and branch next-PC selection
module pc_unit
    import tinker_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000  // First fetch address
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        pc_write,  // EXECUTE for branches, WRITEBACK otherwise
    inst_fields_if.user fields,
    input  word_t       rs_val,
    input  word_t       rt_val,
    input  word_t       rd_val,    // Branch target or offset
    output word_t       pc
);

    word_t pc_seq;   // Fall-through address
    word_t pc_next;  // Selected next PC
    logic  gt;       // brgt condition

    assign pc_seq = pc + 64'd4;
    assign gt     = $signed(rs_val) > $signed(rt_val);

    // ----------------------------------------------------------------------
    // Next PC
    // ----------------------------------------------------------------------
    always_comb begin
        case (fields.opcode)
            OP_BR:   pc_next = rd_val;
            OP_BRR:  pc_next = pc + rd_val;           // Relative to branch itself
            OP_BRGT: pc_next = gt ? rd_val : pc_seq;  // Untaken still advances
            default: pc_next = pc_seq;
        endcase
    end

    // ----------------------------------------------------------------------
    // PC register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

endmodule

// File: logic/core_control.sv
// Multi-cycle FSM with ALU and memory data registers, bus and writeback select
module core_control
    import tinker_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    inst_fields_if.user fields,
    input  word_t       alu_result,
    input  word_t       rs_val,      // Store data
    input  word_t       rd_val,      // Store base address
    input  word_t       pc,
    input  word_t       mem_rdata,
    output logic        ir_write,
    output logic        reg_write,
    output word_t       write_data,
    output logic        pc_write,
    output word_t       mem_addr,
    output logic        mem_read,
    output logic        mem_write,
    output word_t       mem_wdata,
    output logic        hlt
);

    state_t state;
    state_t state_next;
    word_t  alu_reg;       // Result captured at end of EXECUTE
    word_t  mem_data_reg;  // Load data captured at end of MEMORY
    logic   load_op;
    logic   store_op;

    assign load_op  = is_load(fields.opcode);
    assign store_op = is_store(fields.opcode);

    // ----------------------------------------------------------------------
    // State register and transitions
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_FETCH:  state_next = S_DECODE;
            S_DECODE: begin
                state_next = (fields.opcode == OP_HALT) ? S_HALTED : S_EXECUTE;
            end
            S_EXECUTE: begin
                if (load_op || store_op) begin
                    state_next = S_MEMORY;
                end else if (is_branch(fields.opcode)) begin
                    state_next = S_FETCH;  // PC already written
                end else begin
                    state_next = S_WRITEBACK;
                end
            end
            S_MEMORY:    state_next = S_WRITEBACK;
            S_WRITEBACK: state_next = S_FETCH;
            S_HALTED:    state_next = S_HALTED;  // Left only by reset
            default:     state_next = S_FETCH;
        endcase
    end

    // ----------------------------------------------------------------------
    // Per-state strobes and bus address
    // ----------------------------------------------------------------------
    always_comb begin
        ir_write  = 1'b0;
        reg_write = 1'b0;
        pc_write  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        hlt       = 1'b0;
        mem_addr  = alu_reg;  // Load address
        case (state)
            S_FETCH: begin
                ir_write = 1'b1;
                mem_read = 1'b1;
                mem_addr = pc;
            end
            S_EXECUTE: pc_write = is_branch(fields.opcode);
            S_MEMORY: begin
                mem_read  = load_op;
                mem_write = store_op;
                if (store_op) begin
                    mem_addr = rd_val + fields.imm;  // Store base is rd
                end
            end
            S_WRITEBACK: begin
                reg_write = writes_reg(fields.opcode);
                pc_write  = 1'b1;  // Sequential advance
            end
            S_HALTED: hlt = 1'b1;
            default: begin
            end
        endcase
    end

    // Data registers
    always_ff @(posedge clk) begin
        if (state == S_EXECUTE) begin
            alu_reg <= alu_result;
        end
        if (state == S_MEMORY && load_op) begin
            mem_data_reg <= mem_rdata;
        end
    end

    assign write_data = load_op ? mem_data_reg : alu_reg;
    assign mem_wdata  = rs_val;  // Only sampled by memory on mem_write

endmodule

// File: logic/tinker_core.sv
// Tinker core top level, datapath units wired to an external memory bus
module tinker_core
    import tinker_pkg::*;
#(
    parameter word_t RESET_PC = 64'h2000  // Program entry point
) (
    input  logic  clk,
    input  logic  reset,
    output word_t mem_addr,
    output logic  mem_read,
    output logic  mem_write,
    output word_t mem_wdata,
    input  word_t mem_rdata,   // Combinational read data
    output logic  hlt
);

    // ----------------------------------------------------------------------
    // Internal nets
    // ----------------------------------------------------------------------
    word_t rs_val;
    word_t rt_val;
    word_t rd_val;
    word_t alu_result;
    word_t write_data;  // Writeback value
    word_t pc;
    logic  ir_write;
    logic  reg_write;
    logic  pc_write;

    inst_fields_if fields ();  // Decoded fields bundle

    // ----------------------------------------------------------------------
    // Units
    // ----------------------------------------------------------------------
    inst_decoder decoder (
        .clk      (clk),
        .reset    (reset),
        .ir_write (ir_write),
        .instr_in (mem_rdata[INSTR_W-1:0]),  // Instruction in low word
        .fields   (fields.decoder)
    );

    reg_file_bank regs (
        .clk        (clk),
        .reset      (reset),
        .write_en   (reg_write),
        .write_data (write_data),
        .fields     (fields.user),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rd_val     (rd_val)
    );

    alu_unit alu (
        .fields (fields.user),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .result (alu_result)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_gen (
        .clk      (clk),
        .reset    (reset),
        .pc_write (pc_write),
        .fields   (fields.user),
        .rs_val   (rs_val),
        .rt_val   (rt_val),
        .rd_val   (rd_val),
        .pc       (pc)
    );

    core_control control (
        .clk        (clk),
        .reset      (reset),
        .fields     (fields.user),
        .alu_result (alu_result),
        .rs_val     (rs_val),
        .rd_val     (rd_val),
        .pc         (pc),
        .mem_rdata  (mem_rdata),
        .ir_write   (ir_write),
        .reg_write  (reg_write),
        .write_data (write_data),
        .pc_write   (pc_write),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .hlt        (hlt)
    );

endmodule

// File: tb/tinker_checker.sv
// Bus strobe and halt assertions bound onto the tinker core top level
module tinker_checker (
    input logic clk,
    input logic reset,
    input logic mem_read,
    input logic mem_write,
    input logic hlt
);

    int assert_errors = 0;  // Read back by the testbench summary

    // Read and write strobes are exclusive
    bus_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write both high");
            assert_errors++;
        end

    // Only reset leaves the halted state
    halt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
        else begin
            $error("hlt dropped without reset");
            assert_errors++;
        end

    no_write_halted: assert property (@(posedge clk) disable iff (reset)
        !(hlt && mem_write))
        else begin
            $error("memory write while halted");
            assert_errors++;
        end

endmodule

bind tinker_core tinker_checker checker_inst (
    .clk       (clk),
    .reset     (reset),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .hlt       (hlt)
);

// File: tb/tinker_monitor.sv
// Bus monitor comparing each core store and the restart fetch with expected values
module tinker_monitor
    import tinker_pkg::*;
#(
    parameter word_t PROG_BASE = 64'h2000  // Expected first fetch address
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t mem_addr,
    input  logic  mem_read,
    input  logic  mem_write,
    input  word_t mem_wdata,
    input  logic  hlt,
    output int    value_errors,
    output int    flow_errors
);

    word_t exp_addr_q [$];       // Pending stores of the running program
    word_t exp_data_q [$];
    int    row             = 0;
    int    seen            = 0;  // Stores matched so far in this row
    int    value_count     = 0;
    int    flow_count      = 0;
    logic  restart_pending = 1'b1;

    assign value_errors = value_count;
    assign flow_errors  = flow_count;

    // ----------------------------------------------------------------------
    // Expected list control, called by the testbench
    // ----------------------------------------------------------------------
    task automatic begin_row(int r);
        row  = r;
        seen = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    task automatic expect_store(word_t a, word_t d);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
    endtask

    task automatic close_row(logic halted, logic expect_halt);
        if (exp_addr_q.size() != 0) begin
            $display("row %0d: %0d expected store(s) never happened", row, exp_addr_q.size());
            flow_count++;
        end
        if (halted !== expect_halt) begin
            $display("row %0d: core halt state is %b at end of program, %b was expected",
                     row, halted, expect_halt);
            flow_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Sampling mid cycle, away from the clock edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            restart_pending = 1'b1;
        end else begin
            if (restart_pending) begin  // First FETCH after reset
                restart_pending = 1'b0;
                if (mem_read !== 1'b1 || mem_write !== 1'b0 || hlt !== 1'b0 ||
                    mem_addr !== PROG_BASE) begin
                    $display("error at %0t: restart addr %h rd %b wr %b hlt %b, expected %h 1 0 0",
                             $time, mem_addr, mem_read, mem_write, hlt, PROG_BASE);
                    value_count++;
                end
            end
            if (mem_write) begin
                if (exp_addr_q.size() == 0) begin
                    $display("row %0d: unexpected extra store of %h to %h at time %0t",
                             row, mem_wdata, mem_addr, $time);
                    flow_count++;
                end else begin
                    if (mem_addr !== exp_addr_q[0] || mem_wdata !== exp_data_q[0]) begin
                        $display("error at %0t: row %0d store %0d got %h <- %h, expected %h <- %h",
                                 $time, row, seen, mem_addr, mem_wdata,
                                 exp_addr_q[0], exp_data_q[0]);
                        value_count++;
                    end
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    seen++;
                end
            end
        end
    end

endmodule

// File: tb/tinker_tb.sv
// Testbench for the tinker core with a byte memory model and a table of programs
module tinker_tb
    import tinker_pkg::*;
();

    localparam int          CLK_PERIOD    = 20;
    localparam int          RESET_CYCLES  = 5;
    localparam int          NROWS         = 6;
    localparam int          MAX_INSTR     = 16;
    localparam int          MAX_STORES    = 8;
    localparam int          MEM_AW        = 14;
    localparam int          MEM_BYTES     = 1 << MEM_AW;
    localparam int          ROW_CYCLES    = MAX_INSTR * 5;  // Worst case five cycles each
    localparam word_t       PROG_BASE     = 64'h2000;
    localparam logic [11:0] DATA_BASE     = 12'h100;        // Four operand words
    localparam logic [11:0] STORE_BASE    = 12'h400;        // Store slots, eight bytes apart
    localparam int          WATCHDOG_TIME = NROWS * MAX_INSTR * 5 * CLK_PERIOD
                                            + NROWS * 20 * CLK_PERIOD + 1000;

    logic        clk;
    logic        reset;
    word_t       mem_addr;
    logic        mem_read;
    logic        mem_write;
    word_t       mem_wdata;
    word_t       mem_rdata;
    logic        hlt;
    int          value_errors;
    int          flow_errors;
    integer      seed = 32'hec0f_8277;

    logic [7:0]  mem [MEM_BYTES];   // Little-endian byte memory
    logic [MEM_AW-1:0] ra;

    // Program table, one row per program
    instr_t      prog       [NROWS][MAX_INSTR];
    word_t       data_words [NROWS][4];
    word_t       exp_addr   [NROWS][MAX_STORES];
    word_t       exp_data   [NROWS][MAX_STORES];
    int          n_instr    [NROWS];
    int          n_exp      [NROWS];
    logic        exp_halt   [NROWS];

    tinker_core #(
        .RESET_PC (PROG_BASE)
    ) tinker_core_inst (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .hlt       (hlt)
    );

    tinker_monitor #(
        .PROG_BASE (PROG_BASE)
    ) tinker_monitor_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .hlt          (hlt),
        .value_errors (value_errors),
        .flow_errors  (flow_errors)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // Memory model
    // ----------------------------------------------------------------------
    assign ra        = mem_addr[MEM_AW-1:0];
    assign mem_rdata = {mem[ra + 14'd7], mem[ra + 14'd6], mem[ra + 14'd5], mem[ra + 14'd4],
                        mem[ra + 14'd3], mem[ra + 14'd2], mem[ra + 14'd1], mem[ra]};

    always @(posedge clk) begin
        if (mem_write) begin
            for (int b = 0; b < 8; b++) begin
                mem[ra + 14'(b)] = mem_wdata[8*b +: 8];
            end
        end
    end

    function automatic logic [7:0] fill_byte(logic [MEM_AW-1:0] a);
        return a[7:0] ^ a[13:6];  // Mixes every address bit
    endfunction

    // ----------------------------------------------------------------------
    // Table building
    // ----------------------------------------------------------------------
    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic instr_t encode(opcode_t op, int rd, int rs, int rt, logic [11:0] lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    function automatic word_t sext(logic [11:0] lit);
        return {{(XLEN-LIT_W){lit[11]}}, lit};
    endfunction

    task automatic emit(int r, instr_t w);
        prog[r][n_instr[r]] = w;
        n_instr[r]++;
    endtask

    task automatic expect_entry(int r, word_t a, word_t d);
        exp_addr[r][n_exp[r]] = a;
        exp_data[r][n_exp[r]] = d;
        n_exp[r]++;
    endtask

    // Stores a register to the next free slot with r0 as base
    task automatic store_reg(int r, int rd, word_t value);
        logic [11:0] slot;
        slot = STORE_BASE + 12'(8 * n_exp[r]);
        emit(r, encode(OP_STORE, 0, rd, 0, slot));
        expect_entry(r, word_t'(slot), value);
    endtask

    task automatic op_store(int r, instr_t w, int rd, word_t value);
        emit(r, w);
        store_reg(r, rd, value);
    endtask

    task automatic load_operands(int r, int n);
        for (int i = 0; i < n; i++) begin
            emit(r, encode(OP_LOAD, i + 1, 0, 0, DATA_BASE + 12'(8 * i)));  // ri from word i-1
        end
    endtask

    task automatic build_table();
        word_t       a;
        word_t       b;
        word_t       s;
        word_t       v;
        logic [11:0] n;
        logic [11:0] k;
        logic [11:0] m;
        instr_t      wrong;
        for (int r = 0; r < NROWS; r++) begin
            n_instr[r]  = 0;
            n_exp[r]    = 0;
            exp_halt[r] = 1'b1;
            for (int i = 0; i < 4; i++) begin
                data_words[r][i] = rand_word();
            end
        end
        data_words[1][0] = data_words[1][0] | (64'd1 << 63);  // Sign bit for shr
        data_words[1][2] = (data_words[1][2] & 64'd63) | 64'd1;  // Nonzero shift amount
        data_words[2][0] = data_words[2][0] | (64'd1 << 63);  // Sign bit for shri
        data_words[4][0] = PROG_BASE + 64'd12;  // br target, word 3
        data_words[4][1] = PROG_BASE + 64'd52;  // brgt target, word 13
        wrong = encode(OP_STORE, 0, 0, 0, 12'h4f8);  // Off-path marker

        // Register ALU, first half
        a = data_words[0][0];
        b = data_words[0][1];
        load_operands(0, 2);
        op_store(0, encode(OP_ADD, 3, 1, 2, 0), 3, a + b);
        op_store(0, encode(OP_SUB, 3, 1, 2, 0), 3, a - b);
        op_store(0, encode(OP_AND, 3, 1, 2, 0), 3, a & b);
        op_store(0, encode(OP_OR, 3, 1, 2, 0), 3, a | b);
        emit(0, encode(OP_HALT, 0, 0, 0, 0));

        // Register ALU, second half
        a = data_words[1][0];
        b = data_words[1][1];
        s = data_words[1][2];
        load_operands(1, 3);
        op_store(1, encode(OP_XOR, 4, 1, 2, 0), 4, a ^ b);
        op_store(1, encode(OP_NOT, 4, 1, 2, 0), 4, ~a);
        op_store(1, encode(OP_SHR, 4, 1, 3, 0), 4, a >> s);
        op_store(1, encode(OP_SHL, 4, 1, 3, 0), 4, a << s);
        op_store(1, encode(OP_MOV, 4, 1, 0, 0), 4, a);
        emit(1, encode(OP_HALT, 0, 0, 0, 0));

        // Literal forms, rs field of addi/subi points at r2 and must be ignored
        load_operands(2, 2);
        n = {1'b1, 11'(rand_word())};
        v = data_words[2][0] + sext(n);
        op_store(2, encode(OP_ADDI, 1, 2, 0, n), 1, v);
        n = {1'b1, 11'(rand_word())};
        v = v - sext(n);
        op_store(2, encode(OP_SUBI, 1, 2, 0, n), 1, v);
        k = 12'(rand_word() & 64'd31) | 12'h1;
        op_store(2, encode(OP_SHRI, 3, 1, 0, k), 3, word_t'($signed(v) >>> k));
        k = 12'(rand_word() & 64'd31) | 12'h1;
        op_store(2, encode(OP_SHLI, 4, 1, 0, k), 4, v << k);
        n = {1'b1, 11'(rand_word())};
        op_store(2, encode(OP_MOVI, 5, 0, 0, n), 5, sext(n));
        emit(2, encode(OP_HALT, 0, 0, 0, 0));

        // Load and store with a base register, then r0 writes
        emit(3, encode(OP_MOVI, 2, 0, 0, DATA_BASE));
        emit(3, encode(OP_LOAD, 1, 2, 0, 12'h010));      // Word 2 of the data
        store_reg(3, 1, data_words[3][2]);
        emit(3, encode(OP_STORE, 2, 1, 0, 12'h308));     // r2 base lands on 0x408
        expect_entry(3, 64'h408, data_words[3][2]);
        op_store(3, encode(OP_MOVI, 0, 0, 0, {1'b0, 11'(rand_word())} | 12'h1), 0, '0);
        op_store(3, encode(OP_ADD, 0, 1, 1, 0), 0, '0);
        emit(3, encode(OP_HALT, 0, 0, 0, 0));

        // Branch flow, word index in trailing comments
        m = {1'b0, 11'(rand_word())} | 12'h1;
        n = {1'b1, 11'(rand_word())};
        emit(4, encode(OP_LOAD, 10, 0, 0, DATA_BASE));          // 0
        emit(4, encode(OP_BR, 10, 0, 0, 0));                    // 1 to 3
        emit(4, wrong);                                         // 2
        emit(4, encode(OP_MOVI, 11, 0, 0, 12'd12));             // 3
        emit(4, encode(OP_BRR, 11, 0, 0, 0));                   // 4 to 7
        emit(4, wrong);                                         // 5
        emit(4, wrong);                                         // 6
        op_store(4, encode(OP_MOVI, 1, 0, 0, m), 1, sext(m));   // 7 and 8
        emit(4, encode(OP_MOVI, 2, 0, 0, n));                   // 9
        emit(4, encode(OP_LOAD, 12, 0, 0, DATA_BASE + 12'h8));  // 10
        emit(4, encode(OP_BRGT, 12, 1, 0, 0));                  // 11 taken to 13
        emit(4, wrong);                                         // 12
        emit(4, encode(OP_BRGT, 12, 2, 0, 0));                  // 13 negative, falls through
        store_reg(4, 2, sext(n));                               // 14
        emit(4, encode(OP_HALT, 0, 0, 0, 0));                   // 15

        // Halt stops the core before a trailing store
        m = {1'b0, 11'(rand_word())};
        op_store(5, encode(OP_MOVI, 1, 0, 0, m), 1, sext(m));
        emit(5, encode(OP_HALT, 0, 0, 0, 0));
        emit(5, encode(OP_STORE, 0, 1, 0, 12'h4f8));
    endtask

    // ----------------------------------------------------------------------
    // Running one program
    // ----------------------------------------------------------------------
    task automatic load_memory(int r);
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = fill_byte(MEM_AW'(a));
        end
        for (int i = 0; i < n_instr[r]; i++) begin
            for (int b = 0; b < 4; b++) begin
                mem[PROG_BASE + 4 * i + b] = prog[r][i][8*b +: 8];
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int b = 0; b < 8; b++) begin
                mem[DATA_BASE + 8 * i + b] = data_words[r][i][8*b +: 8];
            end
        end
    endtask

    task automatic run_row(int r);
        int cycles;
        @(posedge clk);
        #1 reset = 1'b1;
        load_memory(r);
        tinker_monitor_inst.begin_row(r);
        for (int i = 0; i < n_exp[r]; i++) begin
            tinker_monitor_inst.expect_store(exp_addr[r][i], exp_data[r][i]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (!hlt && cycles < ROW_CYCLES) begin  // Halt or per-row limit
            @(negedge clk);
            cycles++;
        end
        repeat (4) @(negedge clk);  // Window for stray writes after halt
        tinker_monitor_inst.close_row(hlt, exp_halt[r]);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        int total;
        reset = 1'b1;
        build_table();
        load_memory(0);
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        total = value_errors + flow_errors + tinker_core_inst.checker_inst.assert_errors;
        $display("errors: %0d value, %0d flow, %0d assertion", value_errors, flow_errors,
                 tinker_core_inst.checker_inst.assert_errors);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("run timed out at %0t before all programs finished", $time);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: tinker.f
logic/tinker_pkg.sv
logic/inst_fields_if.sv
logic/inst_decoder.sv
logic/reg_file_bank.sv
logic/alu_unit.sv
logic/pc_unit.sv
logic/core_control.sv
logic/tinker_core.sv
tb/tinker_checker.sv
tb/tinker_monitor.sv
tb/tinker_tb.sv
